/* all.f */
+incdir+verilog
verilog/asym_fifo_pkg.sv
verilog/ext_mem_if.sv
verilog/asym_fifo_ctrl.sv
verilog/asym_converter.sv
verilog/banked_ram.sv
verilog/asym_fifo_top.sv
verification/asym_fifo_props.sv
verification/asym_fifo_tb.sv

/* verification/asym_fifo_props.sv */
`timescale 1ns/1ps
`include "asym_fifo_settings.svh"

module asym_fifo_props import asym_fifo_pkg::*; (
   input logic   clk_i,
   input logic   rst_n_i,
   input logic   w_en_i,
   input logic   r_en_i,
   input logic   w_full_o,
   input logic   r_empty_o,
   input level_t r_level_o
);

   // read back by the testbench at the end of the run
   int unsigned fail_count = 0;

   logic w_acc;
   logic r_acc;

   assign w_acc = w_en_i & ~w_full_o;
   assign r_acc = r_en_i & ~r_empty_o;

   a_flags_exclusive: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) !(w_full_o && r_empty_o)
   ) else begin
      fail_count++;
      $error("full and empty are high together");
   end

   a_level_bound: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) r_level_o <= level_t'(`FIFO_DEPTH)
   ) else begin
      fail_count++;
      $error("level %0d is above the capacity", r_level_o);
   end

   // read alone, so the write side adds nothing
   a_read_lowers_level: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
         (r_acc && !w_acc) |=> (r_level_o == $past(r_level_o) - level_t'(1))
   ) else begin
      fail_count++;
      $error("accepted read did not lower the level by one");
   end

   a_empty_after_reset: assert property (
      @(posedge clk_i) !rst_n_i |=> r_empty_o
   ) else begin
      fail_count++;
      $error("empty flag low right after reset");
   end

endmodule

bind asym_fifo_top asym_fifo_props u_props (.*);

/* verification/asym_fifo_tb.sv */
`timescale 1ns/1ps
`include "asym_fifo_settings.svh"

module asym_fifo_tb import asym_fifo_pkg::*; ();

   localparam int RESET_CYCLES  = 3;
   localparam int RAND_OPS      = 500;
   localparam int SIM_OPS       = 4;

   // cycles spent by each test, drains counted at full depth
   localparam int T_RESET       = 1;
   localparam int T_SINGLE      = 1 + 4;
   localparam int T_FILL        = 16 + 1 + `FIFO_DEPTH;
   localparam int T_EMPTY       = 1;
   localparam int T_RANDOM      = RAND_OPS + `FIFO_DEPTH;
   localparam int T_SIMUL       = 1 + SIM_OPS + `FIFO_DEPTH;
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + T_RESET + T_SINGLE + T_FILL + T_EMPTY
                                   + T_RANDOM + T_SIMUL + 200;

   logic    clk;
   logic    rst_n;
   logic    w_en;
   w_data_t w_data;
   logic    r_en;
   r_data_t r_data;
   logic    w_full;
   logic    r_empty;
   level_t  r_level;

   // byte-wide model of the FIFO contents
   r_data_t model_q [$];
   r_data_t last_byte;

   int error_count;
   int check_count;
   int test_count;
   int errors_at_start;
   int cycle_count;
   int bytes_read;

   asym_fifo_top dut (
      .clk_i     (clk),
      .rst_n_i   (rst_n),
      .w_en_i    (w_en),
      .w_data_i  (w_data),
      .w_full_o  (w_full),
      .r_en_i    (r_en),
      .r_data_o  (r_data),
      .r_empty_o (r_empty),
      .r_level_o (r_level)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Simulation failed");
         $finish;
      end
   end

   task automatic check_data(input r_data_t got, input r_data_t exp, input string msg);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("FAIL t=%0t %s: got %h, expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic check_level(input level_t got, input level_t exp, input string msg);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("FAIL t=%0t %s: got %0d, expected %0d", $time, msg, got, exp);
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string msg);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("FAIL t=%0t %s: got %b, expected %b", $time, msg, got, exp);
      end
   endtask

   task automatic report_test(input string name);
      test_count++;
      $display("test %s finished with %0d errors", name, error_count - errors_at_start);
      errors_at_start = error_count;
   endtask

   // one clock with the given requests, entered and left on a falling edge
   task automatic step(input logic we, input w_data_t wd, input logic re);
      logic acc_w;
      logic acc_r;
      int   size;
      acc_w = we && ((`FIFO_DEPTH - model_q.size()) >= `RATIO);
      acc_r = re && (model_q.size() > 0);
      w_en = we;
      w_data = wd;
      r_en = re;
      @(negedge clk);
      w_en = 1'b0;
      r_en = 1'b0;
      if (acc_r) begin
         last_byte = model_q.pop_front();
         bytes_read++;
      end
      if (acc_w) begin
         for (int i = 0; i < `RATIO; i++) begin
            model_q.push_back(wd[i*8 +: 8]);
         end
      end
      size = model_q.size();
      check_data(r_data, last_byte, "read data");
      check_level(r_level, level_t'(size), "fill level");
      check_flag(w_full, (`FIFO_DEPTH - size) < `RATIO, "full flag");
      check_flag(r_empty, size == 0, "empty flag");
   endtask

   task automatic drain_all();
      while (model_q.size() > 0) begin
         step(1'b0, '0, 1'b1);
      end
   endtask

   task automatic test_reset_state();
      check_flag(r_empty, 1'b1, "empty after reset");
      check_flag(w_full, 1'b0, "full after reset");
      check_level(r_level, '0, "level after reset");
      check_data(r_data, '0, "read data after reset");
      report_test("reset_state");
   endtask

   task automatic test_single_word();
      step(1'b1, 32'h0302_0100, 1'b0);
      check_level(r_level, level_t'(4), "level after one word");
      // little-endian, byte 0 comes out first
      for (int i = 0; i < 4; i++) begin
         step(1'b0, '0, 1'b1);
         check_data(r_data, r_data_t'(i), "byte of single word");
         check_level(r_level, level_t'(3 - i), "level during countdown");
      end
      check_flag(r_empty, 1'b1, "empty after single word");
      report_test("single_word");
   endtask

   task automatic test_fill_drain();
      w_data_t word;
      for (int k = 0; k < 16; k++) begin
         for (int i = 0; i < 4; i++) begin
            word[i*8 +: 8] = 8'(8'h80 + 4 * k + i);
         end
         step(1'b1, word, 1'b0);
      end
      check_flag(w_full, 1'b1, "full after sixteen words");
      check_level(r_level, level_t'(`FIFO_DEPTH), "level when full");
      // dropped, the model stays at 64 bytes
      step(1'b1, 32'hdead_beef, 1'b0);
      check_level(r_level, level_t'(`FIFO_DEPTH), "level after write while full");
      for (int n = 0; n < `FIFO_DEPTH; n++) begin
         step(1'b0, '0, 1'b1);
         check_data(r_data, r_data_t'(8'h80 + n), "drained byte");
      end
      report_test("fill_drain");
   endtask

   task automatic test_read_empty();
      r_data_t held;
      held = r_data;
      step(1'b0, '0, 1'b1);
      check_data(r_data, held, "data held on read while empty");
      check_level(r_level, '0, "level on read while empty");
      report_test("read_empty");
   endtask

   task automatic test_random_traffic();
      logic we;
      logic re;
      int   start_bytes;
      start_bytes = bytes_read;
      // writes carry four bytes, so reads come four times as often
      for (int n = 0; n < RAND_OPS; n++) begin
         we = ($urandom_range(0, 4) == 0);
         re = ($urandom_range(0, 4) != 0);
         step(we, w_data_t'($urandom), re);
      end
      drain_all();
      check_flag((bytes_read - start_bytes) >= 3 * `FIFO_DEPTH, 1'b1, "pointer wrapped");
      report_test("random_traffic");
   endtask

   task automatic test_simultaneous();
      level_t prev;
      step(1'b1, w_data_t'($urandom), 1'b0);
      for (int n = 0; n < SIM_OPS; n++) begin
         // expected level comes from the model, four in and one out
         prev = level_t'(model_q.size());
         step(1'b1, w_data_t'($urandom), 1'b1);
         check_level(r_level, prev + level_t'(3), "level after write and read together");
      end
      drain_all();
      report_test("simultaneous");
   endtask

   initial begin
      void'($urandom(49389));
      rst_n = 1'b0;
      w_en = 1'b0;
      w_data = '0;
      r_en = 1'b0;
      last_byte = '0;
      error_count = 0;
      check_count = 0;
      test_count = 0;
      errors_at_start = 0;
      cycle_count = 0;
      bytes_read = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      test_reset_state();
      test_single_word();
      test_fill_drain();
      test_read_empty();
      test_random_traffic();
      test_simultaneous();

      // assertion failures from the bound checker count as errors
      error_count += dut.u_props.fail_count;
      $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
      if (error_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* verilog/asym_converter.sv */
`timescale 1ns/1ps
`include "asym_fifo_settings.svh"

module asym_converter import asym_fifo_pkg::*; (
   input  logic    clk_i,
   input  logic    rst_n_i,

   // write port
   input  logic    w_en_i,
   input  w_addr_t w_addr_i,
   input  w_data_t w_data_i,

   // read port
   input  logic    r_en_i,
   input  r_addr_t r_addr_i,
   output r_data_t r_data_o,

   // banked RAM
   ext_mem_if.conv mem
);

   r_data_t r_lane;
   logic    rd_valid_q;

   // the RAM output register holds garbage until the first read
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rd_valid_q <= 1'b0;
      end else if (r_en_i) begin
         rd_valid_q <= 1'b1;
      end
   end

   assign r_data_o = rd_valid_q ? r_lane : '0;

   generate
      if (`W_DATA_W > `R_DATA_W) begin : g_write_wider
         logic [`RATIO_W-1:0] lane_q;
         mem_data_t           rd_row;

         // a wide write fills one whole row
         assign mem.w_en   = {`RATIO{w_en_i}};
         assign mem.w_addr = w_addr_i;
         assign mem.w_data = w_data_i;

         // narrow read touches a single bank
         assign mem.r_en   = bank_en_t'(r_en_i) << r_addr_i[`RATIO_W-1:0];
         assign mem.r_addr = r_addr_i[`R_ADDR_W-1:`RATIO_W];

         // lane select lines up with the registered RAM read,
         // held between reads so r_data_o stays put
         always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
               lane_q <= '0;
            end else if (r_en_i) begin
               lane_q <= r_addr_i[`RATIO_W-1:0];
            end
         end

         assign rd_row = mem.r_data >> (lane_q * `R_DATA_W);
         assign r_lane = rd_row[`R_DATA_W-1:0];

      end else if (`W_DATA_W < `R_DATA_W) begin : g_read_wider
         // narrow write goes into its own lane
         assign mem.w_en   = bank_en_t'(w_en_i) << w_addr_i[`RATIO_W-1:0];
         assign mem.w_addr = w_addr_i[`W_ADDR_W-1:`RATIO_W];
         assign mem.w_data = mem_data_t'(w_data_i) << (w_addr_i[`RATIO_W-1:0] * `W_DATA_W);

         // wide read takes the whole row
         assign mem.r_en   = {`RATIO{r_en_i}};
         assign mem.r_addr = r_addr_i;
         assign r_lane     = mem.r_data;

      end else begin : g_same_width
         assign mem.w_en   = w_en_i;
         assign mem.w_addr = w_addr_i;
         assign mem.w_data = w_data_i;

         assign mem.r_en   = r_en_i;
         assign mem.r_addr = r_addr_i;
         assign r_lane     = mem.r_data;
      end
   endgenerate

endmodule

/* verilog/asym_fifo_ctrl.sv */
`timescale 1ns/1ps
`include "asym_fifo_settings.svh"

module asym_fifo_ctrl import asym_fifo_pkg::*; (
   input  logic    clk_i,
   input  logic    rst_n_i,

   // requests from the user side
   input  logic    w_en_i,
   input  logic    r_en_i,

   // strobes and addresses towards the converter
   output w_addr_t w_addr_o,
   output r_addr_t r_addr_o,
   output logic    w_acc_o,
   output logic    r_acc_o,

   // status
   output logic    w_full_o,
   output logic    r_empty_o,
   output level_t  r_level_o
);

   w_addr_t w_ptr_q;
   r_addr_t r_ptr_q;
   level_t  level_q;
   level_t  level_d;
   level_t  free_words;
   logic    w_acc;
   logic    r_acc;

   // full once the next write would not fit
   assign free_words = level_t'(`FIFO_DEPTH) - level_q;
   assign w_full_o   = (free_words < level_t'(`W_STEP));
   assign r_empty_o  = (level_q < level_t'(`R_STEP));

   // only accepted operations reach the converter
   assign w_acc = w_en_i & ~w_full_o;
   assign r_acc = r_en_i & ~r_empty_o;

   always_comb begin
      level_d = level_q;
      if (w_acc) begin
         level_d = level_d + level_t'(`W_STEP);
      end
      if (r_acc) begin
         level_d = level_d - level_t'(`R_STEP);
      end
   end

   // pointers wrap on their natural width
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         w_ptr_q <= '0;
      end else if (w_acc) begin
         w_ptr_q <= w_ptr_q + w_addr_t'(1);
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         r_ptr_q <= '0;
      end else if (r_acc) begin
         r_ptr_q <= r_ptr_q + r_addr_t'(1);
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         level_q <= '0;
      end else begin
         level_q <= level_d;
      end
   end

   assign w_addr_o  = w_ptr_q;
   assign r_addr_o  = r_ptr_q;
   assign w_acc_o   = w_acc;
   assign r_acc_o   = r_acc;
   assign r_level_o = level_q;

endmodule

/* verilog/asym_fifo_pkg.sv */
package asym_fifo_pkg;

`include "asym_fifo_settings.svh"

   // data words on each side
   typedef logic [`W_DATA_W-1:0] w_data_t;
   typedef logic [`R_DATA_W-1:0] r_data_t;

   // port addresses
   typedef logic [`W_ADDR_W-1:0] w_addr_t;
   typedef logic [`R_ADDR_W-1:0] r_addr_t;

   // one enable bit per bank
   typedef logic [`RATIO-1:0] bank_en_t;

   // RAM row address and full row
   typedef logic [`MINADDR_W-1:0] mem_addr_t;
   typedef logic [`MAXDATA_W-1:0] mem_data_t;

   // fill level, counted in minimum-width words
   typedef logic [`LEVEL_W-1:0] level_t;

endpackage

/* verilog/asym_fifo_settings.svh */
`ifndef ASYM_FIFO_SETTINGS_SVH
`define ASYM_FIFO_SETTINGS_SVH

// port data widths
`define W_DATA_W 32
`define R_DATA_W 8

// address width in minimum-width words
`define ADDR_W 6

// wide and narrow side of the converter
`define MAXDATA_W ((`W_DATA_W > `R_DATA_W) ? `W_DATA_W : `R_DATA_W)
`define MINDATA_W ((`W_DATA_W > `R_DATA_W) ? `R_DATA_W : `W_DATA_W)

// number of banks and bits to pick one of them
`define RATIO (`MAXDATA_W / `MINDATA_W)
`define RATIO_W ($clog2(`RATIO))

// row address inside each bank
`define MINADDR_W (`ADDR_W - `RATIO_W)

// the wide port addresses rows, the narrow port addresses single words
`define W_ADDR_W ((`W_DATA_W == `MAXDATA_W) ? `MINADDR_W : `ADDR_W)
`define R_ADDR_W ((`R_DATA_W == `MAXDATA_W) ? `MINADDR_W : `ADDR_W)

// minimum words moved by one write or one read
`define W_STEP (`W_DATA_W / `MINDATA_W)
`define R_STEP (`R_DATA_W / `MINDATA_W)

// capacity in minimum words, level needs one extra bit to reach it
`define FIFO_DEPTH (1 << `ADDR_W)
`define LEVEL_W (`ADDR_W + 1)

`endif

/* verilog/asym_fifo_top.sv */
`timescale 1ns/1ps

module asym_fifo_top import asym_fifo_pkg::*; (
   input  logic    clk_i,
   input  logic    rst_n_i,

   // 32-bit write side
   input  logic    w_en_i,
   input  w_data_t w_data_i,
   output logic    w_full_o,

   // 8-bit read side
   input  logic    r_en_i,
   output r_data_t r_data_o,
   output logic    r_empty_o,
   output level_t  r_level_o
);

   w_addr_t w_addr;
   r_addr_t r_addr;
   logic    w_acc;
   logic    r_acc;

   ext_mem_if mem_bus ();

   asym_fifo_ctrl u_ctrl (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .w_en_i    (w_en_i),
      .r_en_i    (r_en_i),
      .w_addr_o  (w_addr),
      .r_addr_o  (r_addr),
      .w_acc_o   (w_acc),
      .r_acc_o   (r_acc),
      .w_full_o  (w_full_o),
      .r_empty_o (r_empty_o),
      .r_level_o (r_level_o)
   );

   asym_converter u_conv (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .w_en_i   (w_acc),
      .w_addr_i (w_addr),
      .w_data_i (w_data_i),
      .r_en_i   (r_acc),
      .r_addr_i (r_addr),
      .r_data_o (r_data_o),
      .mem      (mem_bus.conv)
   );

   banked_ram u_ram (
      .clk_i (clk_i),
      .mem   (mem_bus.mem)
   );

endmodule

/* verilog/banked_ram.sv */
`timescale 1ns/1ps
`include "asym_fifo_settings.svh"

module banked_ram (
   input logic    clk_i,
   ext_mem_if.mem mem
);

   localparam int unsigned ROWS = 2 ** `MINADDR_W;

   // one narrow memory per lane of the wide row
   generate
      for (genvar b = 0; b < `RATIO; b++) begin : g_bank
         logic [`MINDATA_W-1:0] bank_q [ROWS];
         logic [`MINDATA_W-1:0] rd_q;

         always_ff @(posedge clk_i) begin
            if (mem.w_en[b]) begin
               bank_q[mem.w_addr] <= mem.w_data[b*`MINDATA_W +: `MINDATA_W];
            end
         end

         // read register only moves when this bank is read
         always_ff @(posedge clk_i) begin
            if (mem.r_en[b]) begin
               rd_q <= bank_q[mem.r_addr];
            end
         end

         assign mem.r_data[b*`MINDATA_W +: `MINDATA_W] = rd_q;
      end
   endgenerate

endmodule

/* verilog/ext_mem_if.sv */
`timescale 1ns/1ps

interface ext_mem_if import asym_fifo_pkg::*; ();

   // write side of the banked RAM
   bank_en_t  w_en;
   mem_addr_t w_addr;
   mem_data_t w_data;

   // read side, data comes back one cycle after r_en
   bank_en_t  r_en;
   mem_addr_t r_addr;
   mem_data_t r_data;

   // converter drives the RAM
   modport conv (
      output w_en,
      output w_addr,
      output w_data,
      output r_en,
      output r_addr,
      input  r_data
   );

   // RAM side
   modport mem (
      input  w_en,
      input  w_addr,
      input  w_data,
      input  r_en,
      input  r_addr,
      output r_data
   );

endinterface
